/* all.f */
src/hub75_pkg.sv
src/timeout.sv
src/matrix_scan.sv
src/framebuffer.sv
src/pixel_split.sv
src/hub75_top.sv
testbench/hub75_assertions.sv
testbench/hub75_tb.sv

/* src/framebuffer.sv */
module framebuffer (
    input  logic                   reset,
    input  logic                   clk_in,
    input  logic                   write_strobe,
    input  hub75_pkg::fb_address_t write_address,
    input  hub75_pkg::pixel_t      write_data,
    input  hub75_pkg::row_t        row_address,
    input  hub75_pkg::column_t     column_address,
    output hub75_pkg::pixel_t      upper_pixel,
    output hub75_pkg::pixel_t      lower_pixel
);

    // words per half-panel.
    localparam int index_width = $bits(hub75_pkg::row_t) + $bits(hub75_pkg::column_t);
    localparam int depth = 1 << index_width;

    // bank 0 feeds the upper half, bank 1 the lower.
    hub75_pkg::pixel_t bank [2][depth];

    logic [index_width-1:0] write_index;
    logic write_half;
    logic [index_width-1:0] read_index;

    // ***********************************************************************
    // host write port.
    // ***********************************************************************

    // top address bit picks the bank.
    assign write_half = write_address[index_width];
    assign write_index = write_address[index_width-1:0];

    // single-cycle strobe, always accepted.
    always_ff @(posedge clk_in) begin
        if (write_strobe) begin
            bank[write_half][write_index] <= write_data;
        end
    end

    // ***********************************************************************
    // paired read port.
    // ***********************************************************************

    // same row and column in both halves.
    assign read_index = {row_address, column_address};

    // registered, one cycle after the address.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            upper_pixel <= '0;
            lower_pixel <= '0;
        end else begin
            upper_pixel <= bank[0][read_index];
            lower_pixel <= bank[1][read_index];
        end
    end

endmodule

/* src/hub75_pkg.sv */
package hub75_pkg;

    // ***********************************************************************
    // panel geometry.
    // ***********************************************************************

    // pixels shifted per line, per half-panel.
    localparam int columns = 64;

    // bit planes of binary-coded modulation.
    localparam int planes = 6;

    // ***********************************************************************
    // vector types.
    // ***********************************************************************

    // one colour intensity, msb is the brightest plane.
    typedef logic [5:0] channel_t;

    // full pixel, red in the top field, then green, then blue.
    typedef logic [17:0] pixel_t;

    // column index within a line.
    typedef logic [5:0] column_t;

    // row address on the panel connector (1:16 scan).
    typedef logic [3:0] row_t;

    // one-hot plane select.
    // bit 5 is the brightest plane, bit 0 the dimmest.
    typedef logic [5:0] mask_t;

    // output enable length in clock cycles.
    // must hold the brightest plane's on-time.
    typedef logic [9:0] on_time_t;

    // framebuffer address.
    // half select on top, then row, then column.
    // half 0 is the upper half-panel.
    typedef logic [10:0] fb_address_t;

endpackage

/* src/hub75_top.sv */
module hub75_top #(
    parameter hub75_pkg::on_time_t base_on_time = 10'd23,
    parameter hub75_pkg::on_time_t overlap = 10'd67
) (
    input  logic                   reset,
    input  logic                   clk_in,
    input  logic                   write_strobe,
    input  hub75_pkg::fb_address_t write_address,
    input  hub75_pkg::pixel_t      write_data,
    output logic                   red_upper,
    output logic                   green_upper,
    output logic                   blue_upper,
    output logic                   red_lower,
    output logic                   green_lower,
    output logic                   blue_lower,
    output hub75_pkg::row_t        row_address,
    output logic                   clk_pixel,
    output logic                   row_latch,
    output logic                   output_enable
);

    // read side, scan to framebuffer.
    hub75_pkg::column_t scan_column;
    hub75_pkg::row_t scan_row;
    hub75_pkg::mask_t plane_mask;

    // framebuffer to splitter.
    hub75_pkg::pixel_t upper_pixel;
    hub75_pkg::pixel_t lower_pixel;

    framebuffer framebuffer_i (
        .reset(reset),
        .clk_in(clk_in),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .row_address(scan_row),
        .column_address(scan_column),
        .upper_pixel(upper_pixel),
        .lower_pixel(lower_pixel)
    );

    // panel row is the lit one, not the one being shifted.
    // load clock is not used by this panel.
    matrix_scan #(
        .base_on_time(base_on_time),
        .overlap(overlap)
    ) matrix_scan_i (
        .reset(reset),
        .clk_in(clk_in),
        .column_address(scan_column),
        .row_address(scan_row),
        .active_row(row_address),
        .plane_mask(plane_mask),
        .clk_pixel_load(),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable)
    );

    pixel_split pixel_split_i (
        .reset(reset),
        .clk_in(clk_in),
        .plane_mask(plane_mask),
        .upper_pixel(upper_pixel),
        .lower_pixel(lower_pixel),
        .red_upper(red_upper),
        .green_upper(green_upper),
        .blue_upper(blue_upper),
        .red_lower(red_lower),
        .green_lower(green_lower),
        .blue_lower(blue_lower)
    );

endmodule

/* src/matrix_scan.sv */
module matrix_scan #(
    parameter hub75_pkg::on_time_t base_on_time = 10'd23,
    parameter hub75_pkg::on_time_t overlap = 10'd67
) (
    input  logic               reset,
    input  logic               clk_in,
    output hub75_pkg::column_t column_address,
    output hub75_pkg::row_t    row_address,
    output hub75_pkg::row_t    active_row,
    output hub75_pkg::mask_t   plane_mask,
    output logic               clk_pixel_load,
    output logic               clk_pixel,
    output logic               row_latch,
    output logic               output_enable
);

    // wide enough to hold the column count itself.
    localparam int load_width = $clog2(hub75_pkg::columns + 1);
    localparam int column_width = $bits(hub75_pkg::column_t);
    localparam int on_time_width = $bits(hub75_pkg::on_time_t);

    // state advance history, newest in bit 0.
    logic [1:0] state;
    logic clk_state;
    logic state_advance;
    logic shift_idle;

    // load enable and the pixel enable trailing it by half a cycle.
    logic clk_pixel_load_en;
    logic clk_pixel_en;
    logic [1:0] row_latch_state;
    logic latch_done;

    // plane currently lit, one line behind plane_mask.
    hub75_pkg::mask_t active_mask;
    hub75_pkg::on_time_t on_time;
    hub75_pkg::on_time_t on_time_counter;

    // ***********************************************************************
    // shift phase.
    // ***********************************************************************

    // gated clocks, as the panel expects.
    assign clk_pixel_load = clk_in && clk_pixel_load_en;
    assign clk_pixel = clk_in && clk_pixel_en;

    // one load enable per column.
    timeout #(
        .counter_width(load_width)
    ) load_timer (
        .reset(reset),
        .clk_in(clk_in),
        .start(clk_state),
        .value(load_width'(hub75_pkg::columns)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address counts 63 down to 0, then holds.
    // runs out of phase with the pixel clock to cover the read latency.
    timeout #(
        .counter_width(column_width)
    ) column_timer (
        .reset(reset),
        .clk_in(clk_in),
        .start(clk_state),
        .value(column_width'(hub75_pkg::columns - 1)),
        .counter(column_address),
        .running()
    );

    // ***********************************************************************
    // latch, plane and row, all on the falling edge.
    // ***********************************************************************

    // latch high for one cycle once the load enable has dropped.
    assign row_latch = (row_latch_state == 2'b10);

    always_ff @(negedge clk_in) begin
        if (reset) begin
            clk_pixel_en <= 1'b0;
            row_latch_state <= 2'b00;
            plane_mask <= 6'b100000;
            active_mask <= 6'b100000;
            row_address <= '0;
            active_row <= '0;
        end else begin
            clk_pixel_en <= clk_pixel_load_en;
            row_latch_state <= {row_latch_state[0], clk_pixel_load_en};
            if (row_latch) begin
                // the line just shifted becomes the lit one.
                active_mask <= plane_mask;
                active_row <= row_address;
                if (plane_mask[0]) begin
                    // dimmest plane done, next row from the brightest.
                    plane_mask <= 6'b100000;
                    row_address <= row_address + 1'b1;
                end else begin
                    plane_mask <= plane_mask >> 1;
                end
            end
        end
    end

    // ***********************************************************************
    // display phase.
    // ***********************************************************************

    // on-time doubles with every plane.
    always_comb begin
        on_time = '0;
        for (int i = 0; i < hub75_pkg::planes; i++) begin
            if (active_mask[i]) begin
                on_time = base_on_time << i;
            end
        end
    end

    // active mask settles at the end of the latch.
    // start the output enable one edge later.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            latch_done <= 1'b0;
        end else begin
            latch_done <= row_latch;
        end
    end

    // output enable width in cycles equals on_time.
    timeout #(
        .counter_width(on_time_width)
    ) enable_timer (
        .reset(reset),
        .clk_in(clk_in),
        .start(latch_done),
        .value(on_time),
        .counter(on_time_counter),
        .running(output_enable)
    );

    // ***********************************************************************
    // line sequencing.
    // ***********************************************************************

    // no shift, latch or enable load still pending for the current line.
    assign shift_idle = !clk_pixel_load_en && !clk_pixel_en && !row_latch && !latch_done;

    // next shift may overlap the tail of the current on-time.
    assign state_advance = shift_idle && (!output_enable || (on_time_counter < overlap));

    // rising edge of state_advance starts one line.
    assign clk_state = (state == 2'b01);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
        end else begin
            state <= {state[0], state_advance};
        end
    end

endmodule

/* src/pixel_split.sv */
module pixel_split (
    input  logic              reset,
    input  logic              clk_in,
    input  hub75_pkg::mask_t  plane_mask,
    input  hub75_pkg::pixel_t upper_pixel,
    input  hub75_pkg::pixel_t lower_pixel,
    output logic              red_upper,
    output logic              green_upper,
    output logic              blue_upper,
    output logic              red_lower,
    output logic              green_lower,
    output logic              blue_lower
);

    localparam int channel_width = $bits(hub75_pkg::channel_t);

    // mask as seen by the read data, one cycle late.
    hub75_pkg::mask_t mask_q;

    // channel 2 is red, 1 green, 0 blue.
    function automatic hub75_pkg::channel_t channel_of(input hub75_pkg::pixel_t pixel,
                                                       input int index);
        return pixel[index*channel_width +: channel_width];
    endfunction

    // bit of the channel selected by a one-hot mask.
    function automatic logic plane_bit(input hub75_pkg::channel_t channel,
                                       input hub75_pkg::mask_t mask);
        logic picked;
        picked = 1'b0;
        for (int i = 0; i < hub75_pkg::planes; i++) begin
            if (mask[i]) begin
                picked = channel[i];
            end
        end
        return picked;
    endfunction

    // align the mask with the framebuffer output register.
    always_ff @(posedge clk_in) begin
        mask_q <= plane_mask;
    end

    // colour bits, two cycles after their column address.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            red_upper <= 1'b0;
            green_upper <= 1'b0;
            blue_upper <= 1'b0;
            red_lower <= 1'b0;
            green_lower <= 1'b0;
            blue_lower <= 1'b0;
        end else begin
            red_upper <= plane_bit(channel_of(upper_pixel, 2), mask_q);
            green_upper <= plane_bit(channel_of(upper_pixel, 1), mask_q);
            blue_upper <= plane_bit(channel_of(upper_pixel, 0), mask_q);
            red_lower <= plane_bit(channel_of(lower_pixel, 2), mask_q);
            green_lower <= plane_bit(channel_of(lower_pixel, 1), mask_q);
            blue_lower <= plane_bit(channel_of(lower_pixel, 0), mask_q);
        end
    end

endmodule

/* src/timeout.sv */
module timeout #(
    parameter int counter_width = 8
) (
    input  logic                     reset,
    input  logic                     clk_in,
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] counter,
    output logic                     running
);

    // loadable down-counter.
    // start reloads even while running, so a retrigger restarts the count.
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            // stops at zero and waits for the next start.
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after a start.
    assign running = (counter != '0);

endmodule

/* testbench/hub75_assertions.sv */
module hub75_assertions (
    input logic             reset,
    input logic             clk_in,
    input logic             load_enable,
    input logic             row_latch,
    input hub75_pkg::mask_t plane_mask,
    input logic             output_enable
);

    timeunit 1ns;
    timeprecision 100ps;

    // ***********************************************************************
    // scan protocol.
    // ***********************************************************************

    // latch only once the whole line has been shifted.
    // the latch spans the rising edge that could start the next shift,
    // so look at the end of the latch cycle.
    latch_after_load: assert property (
        @(negedge clk_in) disable iff (reset) !(row_latch && load_enable)
    ) else $error("row latch pulsed while the load enable was still high");

    // exactly one bit plane selected at any time.
    mask_one_hot: assert property (
        @(posedge clk_in) disable iff (reset) $onehot(plane_mask)
    ) else $error("plane mask is not one-hot");

    // LEDs dark right out of reset.
    dark_after_reset: assert property (
        @(posedge clk_in) reset |=> !output_enable
    ) else $error("output enable high in the cycle after reset");

endmodule

// internal load enable is only visible inside the scan block.
bind matrix_scan hub75_assertions scan_checks (
    .reset(reset),
    .clk_in(clk_in),
    .load_enable(clk_pixel_load_en),
    .row_latch(row_latch),
    .plane_mask(plane_mask),
    .output_enable(output_enable)
);

/* testbench/hub75_tb.sv */
module hub75_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ***********************************************************************
    // panel timing and run length.
    // ***********************************************************************

    localparam hub75_pkg::on_time_t base_on_time = 10'd23;
    localparam hub75_pkg::on_time_t overlap = 10'd67;
    localparam int clock_period = 40;
    localparam int rows = 16;
    localparam int planes = hub75_pkg::planes;
    localparam int columns = hub75_pkg::columns;
    localparam int words = 1 << $bits(hub75_pkg::fb_address_t);
    // brightest plane plus shift and latch overhead.
    localparam int worst_line = (int'(base_on_time) << (planes - 1)) + columns + 16;
    localparam int frame_lines = rows * planes;
    // two frames, the host fill, and some margin.
    localparam int watchdog_cycles = 2 * frame_lines * worst_line + 2 * words + 1000;

    logic reset;
    logic clk_in;
    logic write_strobe;
    hub75_pkg::fb_address_t write_address;
    hub75_pkg::pixel_t write_data;
    logic red_upper;
    logic green_upper;
    logic blue_upper;
    logic red_lower;
    logic green_lower;
    logic blue_lower;
    hub75_pkg::row_t row_address;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;

    int errors = 0;
    int checks = 0;
    // latches and pixel clock edges seen since reset.
    int latch_count = 0;
    int pixel_edges = 0;
    // reference copy of the framebuffer.
    hub75_pkg::pixel_t pixels [words];

    hub75_top #(
        .base_on_time(base_on_time),
        .overlap(overlap)
    ) dut (
        .reset(reset),
        .clk_in(clk_in),
        .write_strobe(write_strobe),
        .write_address(write_address),
        .write_data(write_data),
        .red_upper(red_upper),
        .green_upper(green_upper),
        .blue_upper(blue_upper),
        .red_lower(red_lower),
        .green_lower(green_lower),
        .blue_lower(blue_lower),
        .row_address(row_address),
        .clk_pixel(clk_pixel),
        .row_latch(row_latch),
        .output_enable(output_enable)
    );

    always #(clock_period / 2) clk_in = ~clk_in;

    // row_latch moves on the falling edge, so the rising edge sees it settled.
    always @(posedge clk_in) begin
        if (!reset && row_latch) begin
            latch_count <= latch_count + 1;
        end
    end

    always @(posedge clk_pixel) begin
        if (!reset) begin
            pixel_edges <= pixel_edges + 1;
        end
    end

    // ***********************************************************************
    // checking and waiting helpers.
    // ***********************************************************************

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s: %s expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string test, input string reason);
        errors++;
        $display("%s: %s", test, reason);
    endtask

    task automatic outputs_low(input string test);
        check_value(test, "output_enable", 1'b0, output_enable);
        check_value(test, "row_latch", 1'b0, row_latch);
        check_value(test, "colour bits", 6'd0,
                    {red_upper, green_upper, blue_upper, red_lower, green_lower, blue_lower});
    endtask

    // returns on the rising edge that sees the latch.
    task automatic wait_for_latch(input string test);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_in);
            cycles++;
        end while (!row_latch && cycles < worst_line);
        assert (row_latch) else report_failure(test, "no row latch within one line time");
    endtask

    // returns on the falling edge after the next pixel clock.
    task automatic wait_pixel_edge(input string test);
        int last;
        int cycles;
        last = pixel_edges;
        cycles = 0;
        do begin
            @(negedge clk_in);
            cycles++;
        end while (pixel_edges == last && cycles < worst_line);
        assert (pixel_edges != last) else report_failure(test, "pixel clock stopped");
    endtask

    // width in cycles, plane and panel row of the next full pulse.
    task automatic measure_pulse(input string test, output int width, output int plane,
                                 output hub75_pkg::row_t row);
        int cycles;
        cycles = 0;
        width = 0;
        @(negedge clk_in);
        // skip a pulse already under way.
        while (output_enable && cycles < worst_line) begin
            @(negedge clk_in);
            cycles++;
        end
        while (!output_enable && cycles < 2 * worst_line) begin
            @(negedge clk_in);
            cycles++;
        end
        assert (output_enable) else report_failure(test, "output enable never went high");
        // line n is lit after latch n + 1.
        plane = planes - 1 - ((latch_count - 1) % planes);
        row = row_address;
        while (output_enable && width <= worst_line) begin
            width++;
            @(negedge clk_in);
        end
    endtask

    task automatic write_pixel(input hub75_pkg::fb_address_t address,
                               input hub75_pkg::pixel_t data);
        @(negedge clk_in);
        write_strobe = 1'b1;
        write_address = address;
        write_data = data;
        pixels[address] = data;
    endtask

    // red, green, blue bit of one plane.
    function automatic logic [2:0] colour_bits(input hub75_pkg::pixel_t pixel, input int plane);
        return {pixel[12 + plane], pixel[6 + plane], pixel[plane]};
    endfunction

    // ***********************************************************************
    // directed tests.
    // ***********************************************************************

    task automatic reset_state();
        reset = 1'b1;
        // first falling edge clears the falling-edge registers.
        @(negedge clk_in);
        repeat (7) begin
            @(negedge clk_in);
            outputs_low("reset_state");
        end
        reset = 1'b0;
        @(negedge clk_in);
        outputs_low("reset_state");
    endtask

    task automatic pixel_clocks_per_line();
        int edges_before;
        wait_for_latch("pixel_clocks_per_line");
        repeat (3) begin
            edges_before = pixel_edges;
            wait_for_latch("pixel_clocks_per_line");
            check_value("pixel_clocks_per_line", "pixel clocks", columns,
                        pixel_edges - edges_before);
        end
    endtask

    task automatic plane_and_row_order();
        int width;
        int plane;
        int run;
        bit synced;
        bit wrapped;
        hub75_pkg::row_t row;
        hub75_pkg::row_t previous;
        hub75_pkg::row_t next_row;
        measure_pulse("plane_and_row_order", width, plane, previous);
        run = 1;
        synced = 1'b0;
        wrapped = 1'b0;
        // a frame and two rows always holds a wrap.
        repeat (frame_lines + 2 * planes) begin
            measure_pulse("plane_and_row_order", width, plane, row);
            if (row == previous) begin
                run++;
                assert (!synced || run <= planes) else
                    report_failure("plane_and_row_order", "row held for more than six pulses");
            end else begin
                next_row = previous + 1'b1;
                check_value("plane_and_row_order", "next row", next_row, row);
                // first run may have started before the test.
                if (synced) begin
                    check_value("plane_and_row_order", "pulses per row", planes, run);
                end
                wrapped = wrapped || (previous == 4'd15);
                synced = 1'b1;
                run = 1;
            end
            previous = row;
        end
        assert (wrapped) else report_failure("plane_and_row_order", "row never wrapped");
    endtask

    task automatic on_time_widths();
        int width;
        int plane;
        int first_plane;
        int expected_plane;
        hub75_pkg::row_t row;
        for (int i = 0; i < planes; i++) begin
            measure_pulse("on_time_widths", width, plane, row);
            if (i == 0) begin
                first_plane = plane;
            end
            // brightest first, dimmest last, then around again.
            expected_plane = (first_plane - i + planes) % planes;
            check_value("on_time_widths", $sformatf("plane %0d on time", expected_plane),
                        int'(base_on_time) << expected_plane, width);
        end
    endtask

    task automatic pixel_data();
        int edge_index;
        int column;
        int row;
        int plane;
        int index;
        for (int a = 0; a < words; a++) begin
            write_pixel(hub75_pkg::fb_address_t'(a), hub75_pkg::pixel_t'($urandom));
        end
        @(negedge clk_in);
        write_strobe = 1'b0;
        // a line already shifting may carry old data.
        wait_for_latch("pixel_data");
        repeat (2 * planes * columns) begin
            wait_pixel_edge("pixel_data");
            edge_index = (pixel_edges - 1) % columns;
            // address runs 63 down to 0 two cycles ahead of the data.
            // first edge still shows the held column 0.
            column = (columns - edge_index) % columns;
            row = (latch_count / planes) % rows;
            plane = planes - 1 - (latch_count % planes);
            index = row * columns + column;
            check_value("pixel_data", $sformatf("upper row %0d column %0d", row, column),
                        colour_bits(pixels[index], plane), {red_upper, green_upper, blue_upper});
            check_value("pixel_data", $sformatf("lower row %0d column %0d", row, column),
                        colour_bits(pixels[words / 2 + index], plane),
                        {red_lower, green_lower, blue_lower});
        end
    endtask

    // ***********************************************************************
    // run control.
    // ***********************************************************************

    initial begin
        clk_in = 1'b0;
        reset = 1'b1;
        write_strobe = 1'b0;
        write_address = '0;
        write_data = '0;
        void'($urandom(32'hd6e9));
        reset_state();
        pixel_clocks_per_line();
        plane_and_row_order();
        on_time_widths();
        pixel_data();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired, the scan stopped making progress");
        $display("%0d checks, %0d errors", checks, errors);
        $display("Something failed");
        $finish;
    end

endmodule
